/* project.f */
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/fe_pkg.sv
rtl/fe_pc_gen.sv
rtl/fe_btb.sv
rtl/fe_ras.sv
rtl/fe_stage_if_sram.sv
rtl/fe_if_id_reg.sv
rtl/fe_top.sv
tb/fe_checker.sv
tb/fe_tb_top.sv

/* tb/fe_tb_top.sv */
module fe_tb_top;

  // Word addresses of the call, the callee entry and the return
  localparam int CALL_W = 20;
  localparam int FUNC_W = 60;
  localparam int RET_W  = 62;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        imem_arvalid;
  logic [31:0] imem_araddr;
  logic [31:0] imem_rdata;
  logic        redirect_valid;
  logic [31:0] redirect_pc;
  logic        upd_valid;
  logic [31:0] upd_pc;
  logic [31:0] upd_tgt;
  logic        upd_taken;
  logic        upd_is_return;
  logic        m_ready;
  logic [31:0] instr_id;
  logic        valid_id;
  logic [31:0] pc_id;
  logic [31:0] pc_plus4_id;
  logic        btb_hit_id;
  logic        pred_taken_id;
  logic [31:0] btb_tgt_id;
  logic        btb_is_return_id;
  logic        ras_valid_id;
  logic [31:0] ras_tgt_id;

  logic        report_req;
  logic        report_done;
  int          error_count;
  int          items_consumed;

  integer      seed;
  logic [31:0] mem [256];

  // Zero-latency instruction memory, 1 KB window
  assign imem_rdata = mem[imem_araddr[9:2]];

  initial begin
    forever #2 clk = ~clk;
  end

  fe_top fe_top_inst (
    .clk (clk), .rst_n (rst_n),
    .imem_arvalid (imem_arvalid), .imem_araddr (imem_araddr), .imem_rdata (imem_rdata),
    .redirect_valid (redirect_valid), .redirect_pc (redirect_pc),
    .upd_valid (upd_valid), .upd_pc (upd_pc), .upd_tgt (upd_tgt),
    .upd_taken (upd_taken), .upd_is_return (upd_is_return),
    .m_ready (m_ready),
    .instr_id (instr_id), .valid_id (valid_id), .pc_id (pc_id), .pc_plus4_id (pc_plus4_id),
    .btb_hit_id (btb_hit_id), .pred_taken_id (pred_taken_id), .btb_tgt_id (btb_tgt_id),
    .btb_is_return_id (btb_is_return_id), .ras_valid_id (ras_valid_id),
    .ras_tgt_id (ras_tgt_id)
  );

  fe_checker fe_checker_inst (
    .clk (clk), .rst_n (rst_n), .m_ready (m_ready),
    .redirect_valid (redirect_valid), .redirect_pc (redirect_pc),
    .upd_valid (upd_valid), .upd_pc (upd_pc), .upd_tgt (upd_tgt),
    .upd_taken (upd_taken), .upd_is_return (upd_is_return),
    .imem_arvalid (imem_arvalid), .imem_araddr (imem_araddr), .imem_rdata (imem_rdata),
    .instr_id (instr_id), .valid_id (valid_id), .pc_id (pc_id), .pc_plus4_id (pc_plus4_id),
    .btb_hit_id (btb_hit_id), .pred_taken_id (pred_taken_id), .btb_tgt_id (btb_tgt_id),
    .btb_is_return_id (btb_is_return_id), .ras_valid_id (ras_valid_id),
    .ras_tgt_id (ras_tgt_id),
    .report_req (report_req), .report_done (report_done),
    .error_count (error_count), .items_consumed (items_consumed)
  );

  // Random ALU words, then one call and one return
  task automatic fill_program();
    logic [31:0] r;
    for (int i = 0; i < 256; i++) begin
      r = $random(seed);
      mem[i] = {r[31:20], r[19:15], 3'b000, r[11:7], rv_isa_pkg::OP_OP_IMM};
    end
    mem[CALL_W] = {20'h00000, rv_isa_pkg::REG_RA, rv_isa_pkg::OP_JAL};
    mem[RET_W]  = {12'h000, rv_isa_pkg::REG_RA, 3'b000, rv_isa_pkg::REG_ZERO,
                   rv_isa_pkg::OP_JALR};
  endtask

  // One cycle of random ready, redirect and BTB traffic
  task automatic drive_cycle(input int cyc);
    logic [31:0] r;
    logic [31:0] u;
    r = $random(seed);
    u = $random(seed);
    m_ready        <= (r[3:0] < 4'd11);
    redirect_valid <= (r[7:4] == 4'd0);
    // Half of the redirects run into the call sequence
    redirect_pc    <= r[12] ? 32'h40 : {22'b0, r[20:13], 2'b00};
    upd_valid      <= 1'b0;
    if (cyc % 40 == 0) begin
      upd_valid     <= 1'b1;
      upd_pc        <= CALL_W * 4;
      upd_tgt       <= FUNC_W * 4;
      upd_taken     <= 1'b1;
      upd_is_return <= 1'b0;
    end else if (cyc % 40 == 20) begin
      upd_valid     <= 1'b1;
      upd_pc        <= RET_W * 4;
      upd_tgt       <= CALL_W * 4 + 4;
      upd_taken     <= 1'b1;
      upd_is_return <= 1'b1;
    end else if (r[27:24] == 4'd0) begin
      upd_valid     <= 1'b1;
      upd_pc        <= {22'b0, u[7:0], 2'b00};
      upd_tgt       <= {22'b0, u[15:8], 2'b00};
      upd_taken     <= u[16];
      upd_is_return <= u[17] & u[18];
    end
  endtask

  initial begin
    int  cycles;
    int  wait_cnt;
    logic timed_out;
    seed           = 32'hdfd7fdd6;
    rst_n          = 1'b0;
    m_ready        = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    upd_valid      = 1'b0;
    upd_pc         = '0;
    upd_tgt        = '0;
    upd_taken      = 1'b0;
    upd_is_return  = 1'b0;
    report_req     = 1'b0;
    timed_out      = 1'b0;
    fill_program();
    repeat (10) @(posedge clk);
    rst_n   <= 1'b1;
    m_ready <= 1'b1;
    // Quiet start so the first item comes from the reset PC
    repeat (3) @(posedge clk);
    cycles = 0;
    while (items_consumed < 400 && cycles < 6000) begin
      @(posedge clk);
      drive_cycle(cycles);
      cycles++;
    end
    if (items_consumed < 400) begin
      $display("Timeout: only %0d items consumed in %0d cycles", items_consumed, cycles);
      timed_out = 1'b1;
    end
    @(posedge clk);
    redirect_valid <= 1'b0;
    upd_valid      <= 1'b0;
    report_req     <= 1'b1;
    wait_cnt = 0;
    while (!report_done && wait_cnt < 20) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (!report_done) begin
      $display("Timeout: checker did not finish its report");
    end
    if (timed_out || !report_done || error_count != 0) begin
      $display("SOME TESTS FAILED");
    end else begin
      $display("ALL TESTS PASSED");
    end
    $finish;
  end

endmodule

/* tb/fe_checker.sv */
`include "fe_settings.svh"

module fe_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        m_ready,
  input  logic        redirect_valid,
  input  logic [31:0] redirect_pc,
  input  logic        upd_valid,
  input  logic [31:0] upd_pc,
  input  logic [31:0] upd_tgt,
  input  logic        upd_taken,
  input  logic        upd_is_return,
  input  logic        imem_arvalid,
  input  logic [31:0] imem_araddr,
  input  logic [31:0] imem_rdata,
  input  logic [31:0] instr_id,
  input  logic        valid_id,
  input  logic [31:0] pc_id,
  input  logic [31:0] pc_plus4_id,
  input  logic        btb_hit_id,
  input  logic        pred_taken_id,
  input  logic [31:0] btb_tgt_id,
  input  logic        btb_is_return_id,
  input  logic        ras_valid_id,
  input  logic [31:0] ras_tgt_id,
  input  logic        report_req,
  output logic        report_done,
  output int          error_count,
  output int          items_consumed
);

  localparam int N  = `FE_BTB_ENTRIES;
  localparam int D  = `FE_RAS_DEPTH;
  localparam int IW = $clog2(`FE_BTB_ENTRIES);

  // Test groups
  localparam int T_RESET = 0;
  localparam int T_DATA  = 1;
  localparam int T_HOLD  = 2;
  localparam int T_REDIR = 3;
  localparam int T_BTB   = 4;
  localparam int T_RAS   = 5;

  string       names [6];
  int          n_chk [6];
  int          n_err [6];

  // Model state: fetch PC, pending flush, ID register
  logic [31:0] m_pc;
  logic        m_pend;
  logic        m_valid;
  logic [31:0] m_instr;
  logic [31:0] m_pcid;
  logic        m_hit;
  logic        m_taken;
  logic        m_ret;
  logic        m_rasv;
  logic [31:0] m_tgt;
  logic [31:0] m_rtgt;

  // Model BTB keeps the full branch address as its tag
  logic        b_v   [N];
  logic [31:0] b_pc  [N];
  logic [31:0] b_tgt [N];
  logic        b_tk  [N];
  logic        b_ret [N];

  logic [31:0] r_stk [D];
  int          r_ptr;
  int          r_cnt;

  // Lookup results for the current model PC
  int          idx;
  logic        l_hit;
  logic        l_taken;
  logic        l_ret;
  logic [31:0] l_tgt;
  logic        l_rasv;
  logic [31:0] l_rtgt;
  logic        flush;
  logic        consumed;
  logic        seen_first;
  logic        redir_armed;
  logic [31:0] redir_pc;

  // Previous sample for the stall hold check
  logic        p_stall;
  logic [31:0] p_val [10];
  logic [31:0] c_val [10];
  string       fld_names [10];

  initial begin
    names = '{"reset", "fetch data", "stall hold", "redirect", "btb predict", "ras return"};
    fld_names = '{"valid_id", "instr_id", "pc_id", "pc_plus4_id", "btb_hit_id",
                  "pred_taken_id", "btb_tgt_id", "btb_is_return_id", "ras_valid_id",
                  "ras_tgt_id"};
    n_chk = '{default: 0};
    n_err = '{default: 0};
    report_done    = 1'b0;
    error_count    = 0;
    items_consumed = 0;
    p_stall        = 1'b0;
  end

  task automatic check_val(input string sig, input logic [31:0] exp, input logic [31:0] act,
                           input int grp);
    n_chk[grp]++;
    if (act !== exp) begin
      n_err[grp]++;
      error_count++;
      $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, sig, exp, act);
    end
  endtask

  always @(negedge clk) begin
    c_val = '{valid_id, instr_id, pc_id, pc_plus4_id, btb_hit_id, pred_taken_id,
              btb_tgt_id, btb_is_return_id, ras_valid_id, ras_tgt_id};
    if (!rst_n) begin
      check_val("valid_id", 32'd0, valid_id, T_RESET);
      check_val("imem_araddr", `FE_RESET_PC, imem_araddr, T_RESET);
      m_pc        = `FE_RESET_PC;
      m_pend      = 1'b0;
      m_valid     = 1'b0;
      r_ptr       = 0;
      r_cnt       = 0;
      seen_first  = 1'b0;
      redir_armed = 1'b0;
      for (int i = 0; i < N; i++) b_v[i] = 1'b0;
      p_stall = 1'b0;
    end else begin
      // Compare the DUT against the model state
      check_val("imem_araddr", m_pc, imem_araddr, T_DATA);
      check_val("imem_arvalid", 32'd1, imem_arvalid, T_DATA);
      check_val("valid_id", m_valid, valid_id, T_DATA);
      if (p_stall) begin
        for (int i = 0; i < 10; i++) begin
          check_val($sformatf("%s held", fld_names[i]), p_val[i], c_val[i], T_HOLD);
        end
      end
      if (m_valid) begin
        if (!seen_first) begin
          check_val("pc_id", `FE_RESET_PC, pc_id, T_RESET);
          seen_first = 1'b1;
        end
        check_val("instr_id", m_instr, instr_id, T_DATA);
        check_val("pc_id", m_pcid, pc_id, T_DATA);
        check_val("pc_plus4_id", m_pcid + 32'd4, pc_plus4_id, T_DATA);
        check_val("btb_hit_id", m_hit, btb_hit_id, T_BTB);
        check_val("pred_taken_id", m_taken, pred_taken_id, T_BTB);
        check_val("btb_is_return_id", m_ret, btb_is_return_id, T_BTB);
        if (m_hit) check_val("btb_tgt_id", m_tgt, btb_tgt_id, T_BTB);
        check_val("ras_valid_id", m_rasv, ras_valid_id, T_DATA);
        if (m_rasv && m_ret) check_val("ras_tgt_id", m_rtgt, ras_tgt_id, T_RAS);
        // First item consumed after the flush edge must be the redirect target
        if (m_ready && redir_armed) begin
          check_val("pc_id after redirect", redir_pc, pc_id, T_REDIR);
          redir_armed = 1'b0;
        end
      end
      // Lookups on the pre-edge state
      idx     = (m_pc >> 2) % N;
      l_hit   = b_v[idx] && ((b_pc[idx] >> (2 + IW)) == (m_pc >> (2 + IW)));
      l_taken = l_hit & b_tk[idx];
      l_ret   = l_hit & b_ret[idx];
      l_tgt   = b_tgt[idx];
      l_rasv  = (r_cnt != 0);
      l_rtgt  = r_stk[(r_ptr + D - 1) % D];
      flush    = redirect_valid | m_pend;
      consumed = m_valid & m_ready;
      if (consumed) begin
        items_consumed++;
        // jal ra pushes the link, jalr x0 0(ra) pops
        if (m_instr[6:0] == rv_isa_pkg::OP_JAL && m_instr[11:7] == rv_isa_pkg::REG_RA) begin
          r_stk[r_ptr] = m_pcid + 32'd4;
          r_ptr = (r_ptr + 1) % D;
          if (r_cnt < D) r_cnt++;
        end else if (m_instr[6:0] == rv_isa_pkg::OP_JALR &&
                     m_instr[19:15] == rv_isa_pkg::REG_RA &&
                     m_instr[11:7] == rv_isa_pkg::REG_ZERO && r_cnt > 0) begin
          r_ptr = (r_ptr + D - 1) % D;
          r_cnt--;
        end
      end
      // A newer redirect replaces any older target still in flight
      if (redirect_valid) begin
        redir_armed = 1'b0;
        redir_pc    = redirect_pc;
      end
      // Item held in ID during a stall is older than the redirect
      if (m_ready && flush) begin
        redir_armed = 1'b1;
      end
      if (m_ready) begin
        m_valid = !flush;
        m_instr = flush ? rv_isa_pkg::I_NOP : imem_rdata;
        m_pcid  = m_pc;
        m_hit   = l_hit & !flush;
        m_taken = l_taken & !flush;
        m_ret   = l_ret & !flush;
        m_rasv  = l_rasv & !flush;
        m_tgt   = l_tgt;
        m_rtgt  = l_rtgt;
      end
      // Next PC by priority
      if (redirect_valid) begin
        m_pc = redirect_pc;
      end else if (m_ready && !m_pend) begin
        if (l_ret && l_rasv) m_pc = l_rtgt;
        else if (l_taken) m_pc = l_tgt;
        else m_pc = m_pc + 32'd4;
      end
      m_pend = flush & !m_ready;
      if (upd_valid) begin
        idx        = (upd_pc >> 2) % N;
        b_v[idx]   = 1'b1;
        b_pc[idx]  = upd_pc;
        b_tgt[idx] = upd_tgt;
        b_tk[idx]  = upd_taken;
        b_ret[idx] = upd_is_return;
      end
      p_stall = !m_ready;
    end
    p_val = c_val;
    if (report_req && !report_done) begin
      for (int g = 0; g < 6; g++) begin
        // A group that never ran counts against the run
        if (n_chk[g] == 0) begin
          error_count++;
          $display("test %s: no checks were run", names[g]);
        end else begin
          $display("test %s: %0d checks, %0d errors", names[g], n_chk[g], n_err[g]);
        end
      end
      $display("Totals: %0d items consumed, %0d errors", items_consumed, error_count);
      report_done = 1'b1;
    end
  end

endmodule

/* rtl/fe_top.sv */
module fe_top (
  input  logic               clk,
  input  logic               rst_n,

  // SRAM read port
  output logic               imem_arvalid,
  output fe_pkg::pc_t        imem_araddr,
  input  rv_isa_pkg::instr_t imem_rdata,

  // Redirect from execute
  input  logic               redirect_valid,
  input  fe_pkg::pc_t        redirect_pc,

  // BTB update from execute
  input  logic               upd_valid,
  input  fe_pkg::pc_t        upd_pc,
  input  fe_pkg::pc_t        upd_tgt,
  input  logic               upd_taken,
  input  logic               upd_is_return,

  input  logic               m_ready,

  // ID-side outputs
  output rv_isa_pkg::instr_t instr_id,
  output logic               valid_id,
  output fe_pkg::pc_t        pc_id,
  output fe_pkg::pc_t        pc_plus4_id,
  output logic               btb_hit_id,
  output logic               pred_taken_id,
  output fe_pkg::pc_t        btb_tgt_id,
  output logic               btb_is_return_id,
  output logic               ras_valid_id,
  output fe_pkg::pc_t        ras_tgt_id
);

  fe_pkg::pc_t pc;
  logic        if_id_flush;
  logic        btb_hit;
  logic        btb_pred_taken;
  fe_pkg::pc_t btb_tgt;
  logic        btb_is_return;
  logic        ras_valid;
  fe_pkg::pc_t ras_tgt;

  // PC generation
  fe_pc_gen fe_pc_gen_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .m_ready        (m_ready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .btb_hit        (btb_hit),
    .btb_pred_taken (btb_pred_taken),
    .btb_tgt        (btb_tgt),
    .btb_is_return  (btb_is_return),
    .ras_valid      (ras_valid),
    .ras_tgt        (ras_tgt),
    .pc             (pc),
    .if_id_flush    (if_id_flush)
  );

  // Predictors, both looked up in the fetch cycle
  fe_btb fe_btb_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc             (pc),
    .upd_valid      (upd_valid),
    .upd_pc         (upd_pc),
    .upd_tgt        (upd_tgt),
    .upd_taken      (upd_taken),
    .upd_is_return  (upd_is_return),
    .btb_hit        (btb_hit),
    .btb_pred_taken (btb_pred_taken),
    .btb_tgt        (btb_tgt),
    .btb_is_return  (btb_is_return)
  );

  // RAS is trained from the ID side
  fe_ras fe_ras_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .m_ready     (m_ready),
    .valid_id    (valid_id),
    .instr_id    (instr_id),
    .pc_plus4_id (pc_plus4_id),
    .ras_valid   (ras_valid),
    .ras_tgt     (ras_tgt)
  );

  // Fetch stage
  fe_stage_if_sram fe_stage_if_sram_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc           (pc),
    .if_id_flush  (if_id_flush),
    .m_ready      (m_ready),
    .imem_arvalid (imem_arvalid),
    .imem_araddr  (imem_araddr),
    .imem_rdata   (imem_rdata),
    .instr_id     (instr_id),
    .valid_id     (valid_id)
  );

  // IF/ID side fields
  fe_if_id_reg fe_if_id_reg_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .m_ready          (m_ready),
    .if_id_flush      (if_id_flush),
    .pc               (pc),
    .btb_hit          (btb_hit),
    .btb_pred_taken   (btb_pred_taken),
    .btb_tgt          (btb_tgt),
    .btb_is_return    (btb_is_return),
    .ras_valid        (ras_valid),
    .ras_tgt          (ras_tgt),
    .pc_id            (pc_id),
    .pc_plus4_id      (pc_plus4_id),
    .btb_hit_id       (btb_hit_id),
    .pred_taken_id    (pred_taken_id),
    .btb_tgt_id       (btb_tgt_id),
    .btb_is_return_id (btb_is_return_id),
    .ras_valid_id     (ras_valid_id),
    .ras_tgt_id       (ras_tgt_id)
  );

endmodule

/* rtl/fe_if_id_reg.sv */
module fe_if_id_reg (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        m_ready,
  input  logic        if_id_flush,

  // Fetch-side fields for the instruction at pc
  input  fe_pkg::pc_t pc,
  input  logic        btb_hit,
  input  logic        btb_pred_taken,
  input  fe_pkg::pc_t btb_tgt,
  input  logic        btb_is_return,
  input  logic        ras_valid,
  input  fe_pkg::pc_t ras_tgt,

  // ID-side copies, aligned with instr_id
  output fe_pkg::pc_t pc_id,
  output fe_pkg::pc_t pc_plus4_id,
  output logic        btb_hit_id,
  output logic        pred_taken_id,
  output fe_pkg::pc_t btb_tgt_id,
  output logic        btb_is_return_id,
  output logic        ras_valid_id,
  output fe_pkg::pc_t ras_tgt_id
);

  fe_pkg::pc_t pc_plus4;

  // Link address for calls
  assign pc_plus4 = pc + fe_pkg::pc_t'(4);

  // Prediction bits, cleared on reset and on a flush edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      btb_hit_id       <= 1'b0;
      pred_taken_id    <= 1'b0;
      btb_is_return_id <= 1'b0;
      ras_valid_id     <= 1'b0;
    end else if (m_ready) begin
      btb_hit_id       <= btb_hit & ~if_id_flush;
      pred_taken_id    <= btb_pred_taken & ~if_id_flush;
      btb_is_return_id <= btb_is_return & ~if_id_flush;
      ras_valid_id     <= ras_valid & ~if_id_flush;
    end
  end

  // Address payload, same enable as the instruction buffer
  always_ff @(posedge clk) begin
    if (m_ready) begin
      pc_id       <= pc;
      pc_plus4_id <= pc_plus4;
      btb_tgt_id  <= btb_tgt;
      ras_tgt_id  <= ras_tgt;
    end
  end

endmodule

/* rtl/fe_stage_if_sram.sv */
module fe_stage_if_sram (
  input  logic               clk,
  input  logic               rst_n,

  // Fetch address from the PC generator
  input  fe_pkg::pc_t        pc,

  // Flush request, acts only on an edge with m_ready
  input  logic               if_id_flush,

  // Back-pressure from ID
  input  logic               m_ready,

  // Zero-latency SRAM read port
  output logic               imem_arvalid,
  output fe_pkg::pc_t        imem_araddr,
  input  rv_isa_pkg::instr_t imem_rdata,

  // Buffered instruction toward ID
  output rv_isa_pkg::instr_t instr_id,
  output logic               valid_id
);

  rv_isa_pkg::instr_t instr_buf;
  logic               valid_buf;

  // SRAM is always enabled, data comes back in the same cycle
  assign imem_arvalid = 1'b1;
  assign imem_araddr  = pc;

  // Instruction buffer
  // A stall holds the current item even with a flush pending,
  // the flush lands on the first edge with m_ready
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr_buf <= rv_isa_pkg::I_NOP;
      valid_buf <= 1'b0;
    end else if (m_ready) begin
      if (if_id_flush) begin
        // Squash into a bubble
        instr_buf <= rv_isa_pkg::I_NOP;
        valid_buf <= 1'b0;
      end else begin
        instr_buf <= imem_rdata;
        valid_buf <= 1'b1;
      end
    end
  end

  assign instr_id = instr_buf;
  assign valid_id = valid_buf;

endmodule

/* rtl/fe_ras.sv */
`include "fe_settings.svh"

module fe_ras (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               m_ready,

  // ID-side view used by predecode
  input  logic               valid_id,
  input  rv_isa_pkg::instr_t instr_id,
  input  fe_pkg::pc_t        pc_plus4_id,

  // Current top of stack
  output logic               ras_valid,
  output fe_pkg::pc_t        ras_tgt
);

  localparam int CNT_W = $clog2(`FE_RAS_DEPTH + 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`FE_RAS_DEPTH);

  fe_pkg::pc_t      stack_q [`FE_RAS_DEPTH];
  fe_pkg::ras_ptr_t ptr_q;
  fe_pkg::ras_ptr_t top_ptr;
  logic [CNT_W-1:0] count_q;

  logic consumed;
  logic is_call;
  logic is_return;

  // Predecode only acts on an instruction leaving ID
  assign consumed = valid_id & m_ready;

  // jal ra, imm
  assign is_call = consumed && (instr_id[6:0] == rv_isa_pkg::OP_JAL) &&
                   (instr_id[11:7] == rv_isa_pkg::REG_RA);

  // jalr x0, 0(ra)
  assign is_return = consumed && (instr_id[6:0] == rv_isa_pkg::OP_JALR) &&
                     (instr_id[19:15] == rv_isa_pkg::REG_RA) &&
                     (instr_id[11:7] == rv_isa_pkg::REG_ZERO);

  // ptr_q is the next free slot, top is one below
  assign top_ptr   = ptr_q - fe_pkg::ras_ptr_t'(1);
  assign ras_tgt   = stack_q[top_ptr];
  assign ras_valid = (count_q != '0);

  // Pointer and occupancy
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q   <= '0;
      count_q <= '0;
    end else if (is_call) begin
      // Wrap overwrites the oldest entry when full
      ptr_q <= ptr_q + fe_pkg::ras_ptr_t'(1);
      if (count_q != CNT_FULL) begin
        count_q <= count_q + CNT_W'(1);
      end
    end else if (is_return && ras_valid) begin
      ptr_q   <= top_ptr;
      count_q <= count_q - CNT_W'(1);
    end
  end

  // Return address storage
  always_ff @(posedge clk) begin
    if (is_call) begin
      stack_q[ptr_q] <= pc_plus4_id;
    end
  end

endmodule

/* rtl/fe_btb.sv */
`include "fe_settings.svh"

module fe_btb (
  input  logic        clk,
  input  logic        rst_n,

  // Lookup address
  input  fe_pkg::pc_t pc,

  // Update port from execute
  input  logic        upd_valid,
  input  fe_pkg::pc_t upd_pc,
  input  fe_pkg::pc_t upd_tgt,
  input  logic        upd_taken,
  input  logic        upd_is_return,

  // Same-cycle lookup result
  output logic        btb_hit,
  output logic        btb_pred_taken,
  output fe_pkg::pc_t btb_tgt,
  output logic        btb_is_return
);

  localparam int IW = fe_pkg::BTB_IDX_W;

  // Entry storage, only the valid bits are control state
  logic [`FE_BTB_ENTRIES-1:0] valid_q;
  fe_pkg::btb_tag_t           tag_q    [`FE_BTB_ENTRIES];
  fe_pkg::pc_t                tgt_q    [`FE_BTB_ENTRIES];
  logic                       taken_q  [`FE_BTB_ENTRIES];
  logic                       return_q [`FE_BTB_ENTRIES];

  fe_pkg::btb_idx_t lookup_idx;
  fe_pkg::btb_tag_t lookup_tag;
  fe_pkg::btb_idx_t upd_idx;
  fe_pkg::btb_tag_t upd_tag;

  // Split both addresses into index and tag
  assign lookup_idx = pc[IW+1:2];
  assign lookup_tag = pc[`FE_XLEN-1:IW+2];
  assign upd_idx    = upd_pc[IW+1:2];
  assign upd_tag    = upd_pc[`FE_XLEN-1:IW+2];

  // Combinational lookup sees the array before this edge's write
  assign btb_hit        = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
  assign btb_pred_taken = btb_hit & taken_q[lookup_idx];
  assign btb_tgt        = tgt_q[lookup_idx];
  assign btb_is_return  = btb_hit & return_q[lookup_idx];

  // Valid bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (upd_valid) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // Entry payload, overwritten whole on update
  always_ff @(posedge clk) begin
    if (upd_valid) begin
      tag_q[upd_idx]    <= upd_tag;
      tgt_q[upd_idx]    <= upd_tgt;
      taken_q[upd_idx]  <= upd_taken;
      return_q[upd_idx] <= upd_is_return;
    end
  end

endmodule

/* rtl/fe_pc_gen.sv */
`include "fe_settings.svh"

module fe_pc_gen (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        m_ready,

  // Redirect pulse from execute
  input  logic        redirect_valid,
  input  fe_pkg::pc_t redirect_pc,

  // BTB lookup result for the current pc
  input  logic        btb_hit,
  input  logic        btb_pred_taken,
  input  fe_pkg::pc_t btb_tgt,
  input  logic        btb_is_return,

  // Current RAS top
  input  logic        ras_valid,
  input  fe_pkg::pc_t ras_tgt,

  output fe_pkg::pc_t pc,
  output logic        if_id_flush
);

  fe_pkg::pc_t pc_next;
  logic        flush_pending;

  // Predicted next PC, redirect handled at the register
  always_comb begin
    if (btb_hit && btb_is_return && ras_valid) begin
      // Return predicted through the RAS
      pc_next = ras_tgt;
    end else if (btb_hit && btb_pred_taken) begin
      pc_next = btb_tgt;
    end else begin
      pc_next = pc + fe_pkg::pc_t'(4);
    end
  end

  // Flush acts in the redirect cycle itself and while pending
  assign if_id_flush = redirect_valid | flush_pending;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc            <= `FE_RESET_PC;
      flush_pending <= 1'b0;
    end else begin
      // Redirect loads pc even during a stall
      if (redirect_valid) begin
        pc <= redirect_pc;
      end else if (m_ready && !flush_pending) begin
        pc <= pc_next;
      end
      // A pending flush edge discards the fetch, so pc holds on it
      // Keep the flush alive until an edge with m_ready
      flush_pending <= if_id_flush & ~m_ready;
    end
  end

endmodule

/* rtl/fe_pkg.sv */
`include "fe_settings.svh"

package fe_pkg;

  // Fetch address
  typedef logic [`FE_XLEN-1:0] pc_t;

  // BTB index sits just above the halfword/byte offset bits
  localparam int BTB_IDX_W = $clog2(`FE_BTB_ENTRIES);

  // Tag is everything above the index
  localparam int BTB_TAG_W = `FE_XLEN - BTB_IDX_W - 2;

  typedef logic [BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [BTB_TAG_W-1:0] btb_tag_t;

  // RAS slot pointer, wraps on overflow
  localparam int RAS_PTR_W = $clog2(`FE_RAS_DEPTH);

  typedef logic [RAS_PTR_W-1:0] ras_ptr_t;

endpackage

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Raw 32-bit instruction word
  typedef logic [31:0] instr_t;

  // Major opcode field, bits 6:0
  typedef logic [6:0] opcode_t;

  // Architectural register number
  typedef logic [4:0] regnum_t;

  // Opcodes the front end cares about
  localparam opcode_t OP_OP_IMM = 7'b0010011;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;

  // x0 is hardwired zero, x1 is the link register
  localparam regnum_t REG_ZERO = 5'd0;
  localparam regnum_t REG_RA   = 5'd1;

  // addi x0, x0, 0
  localparam instr_t I_NOP = {12'h000, REG_ZERO, 3'b000, REG_ZERO, OP_OP_IMM};

endpackage

/* rtl/fe_settings.svh */
`ifndef FE_SETTINGS_SVH
`define FE_SETTINGS_SVH

// Address and PC width of the front end
`define FE_XLEN 32

// Direct-mapped BTB size, power of two
`define FE_BTB_ENTRIES 16

// Return address stack depth, power of two
`define FE_RAS_DEPTH 4

// First fetch address after reset
`define FE_RESET_PC 32'h0000_0000

`endif
